//--- sources.f
src/spi_map_pkg.sv
src/spi_engine_pkg.sv
src/spi_regs.sv
src/spi_sequencer.sv
src/spi_shifter.sv
src/spi_controller.sv
verification/spi_controller_properties.sv
verification/tb_spi_controller.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the SPI controller testbench with Verilator.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log
binary=sim_tb_spi_controller

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sources.f --top-module tb_spi_controller \
    -Mdir "$build_dir" -o "$binary"; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/$binary" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "SIMULATION PASSED" "$log_file"; then
  exit 0
else
  echo "pass message not found in $log_file"
  exit 1
fi

//--- verification/tb_spi_controller.sv
`timescale 1ns/1ps

module tb_spi_controller;

  import spi_map_pkg::*;

  localparam int clock_period     = 10;
  localparam int readback_rounds  = 6;
  localparam int transfer_count   = 13;
  localparam int watchdog_cycles  = transfer_count * 16 * 9 + 500;
  localparam logic [31:0] lfsr_mask = 32'h8020_0003;

  logic                     clock = 1'b0;
  logic                     reset;
  logic [addr_width-1:0]    rw_address;
  logic [data_width-1:0]    read_data;
  logic                     read_request;
  logic                     read_response;
  logic [data_width-1:0]    write_data;
  logic [strobe_width-1:0]  write_strobe;
  logic                     write_request;
  logic                     write_response;
  logic                     sclk;
  wire                      pico;
  logic                     poci = 1'b0;
  logic [cs_line_count-1:0] cs;

  // reference model of the register bank
  logic                 model_cpol;
  logic                 model_cpha;
  logic [reg_width-1:0] model_cs;
  logic [reg_width-1:0] model_div;
  logic [reg_width-1:0] model_rx;

  // spi device state
  logic                     dev_cpol = 1'b0;
  logic                     dev_cpha = 1'b0;
  logic [reg_width-1:0]     dev_resp = '0;
  logic [reg_width-1:0]     dev_shift = '0;
  logic [reg_width-1:0]     dev_rx = '0;
  logic [cs_line_count-1:0] cs_expect = '1;
  logic                     selected = 1'b0;
  logic                     selected_prev = 1'b0;
  logic                     sclk_prev = 1'b0;
  int                       dev_frames = 0;
  int                       sclk_edges = 0;

  logic [31:0] lfsr_state = 32'h779a_2111;

  spi_controller i_dut (
    .clock          (clock),
    .reset          (reset),
    .rw_address     (rw_address),
    .read_data      (read_data),
    .read_request   (read_request),
    .read_response  (read_response),
    .write_data     (write_data),
    .write_strobe   (write_strobe),
    .write_request  (write_request),
    .write_response (write_response),
    .sclk           (sclk),
    .pico           (pico),
    .poci           (poci),
    .cs             (cs)
  );

  always #(clock_period / 2) clock = ~clock;

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    lfsr_next = state[0] ? ((state >> 1) ^ lfsr_mask) : (state >> 1);
  endfunction

  // one lfsr step per bit taken
  task automatic random_bits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      value      = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic logic [data_width-1:0] to_word(input logic [reg_width-1:0] value);
    to_word = {{(data_width - reg_width){1'b0}}, value};
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [data_width-1:0] actual,
                            input logic [data_width-1:0] expected);
    if (actual !== expected) begin
      report_failure($sformatf("FAILED %s: expected 0x%h, got 0x%h", name, expected, actual));
    end
  endtask

  task automatic check_byte(input string name, input logic [reg_width-1:0] actual,
                            input logic [reg_width-1:0] expected);
    if (actual !== expected) begin
      report_failure($sformatf("FAILED %s: expected 0x%h, got 0x%h", name, expected, actual));
    end
  endtask

  // ------------------------------------------------------------
  // host bus
  // ------------------------------------------------------------
  task automatic bus_write(input logic [addr_width-1:0] address,
                           input logic [data_width-1:0] data,
                           input logic [strobe_width-1:0] strobe);
    @(negedge clock);
    rw_address    = address;
    write_data    = data;
    write_strobe  = strobe;
    write_request = 1'b1;
    @(negedge clock);
    write_request = 1'b0;
    if (write_response !== 1'b1) begin
      report_failure("the DUT did not answer a write one cycle after the request");
    end
  endtask

  task automatic bus_read(input logic [addr_width-1:0] address,
                          output logic [data_width-1:0] data);
    @(negedge clock);
    rw_address   = address;
    read_request = 1'b1;
    @(negedge clock);
    read_request = 1'b0;
    if (read_response !== 1'b1) begin
      report_failure("the DUT did not answer a read one cycle after the request");
    end
    data = read_data;
  endtask

  task automatic check_registers();
    logic [data_width-1:0] word;
    bus_read(reg_cpol, word);
    check_word("cpol", word, to_word(reg_width'(model_cpol)));
    bus_read(reg_cpha, word);
    check_word("cpha", word, to_word(reg_width'(model_cpha)));
    bus_read(reg_chip_select, word);
    check_word("chip_select", word, to_word(model_cs));
    bus_read(reg_clock_div, word);
    check_word("clock_div", word, to_word(model_div));
  endtask

  task automatic pick_strobe(output logic [strobe_width-1:0] strobe);
    logic [31:0] pick;
    random_bits(strobe_width, pick);
    strobe = pick[strobe_width-1:0];
    if (strobe == '0) begin
      strobe = 4'b1000;
    end
  endtask

  // ------------------------------------------------------------
  // spi transfers
  // ------------------------------------------------------------
  task automatic run_transfer(input logic [1:0] mode, input logic [reg_width-1:0] sel,
                              input logic [reg_width-1:0] div, input logic [reg_width-1:0] tx,
                              input logic [reg_width-1:0] resp, input logic overwrite);
    logic [data_width-1:0] word;
    int                    frames_before;
    model_cpol = mode[1];
    model_cpha = mode[0];
    model_cs   = sel;
    model_div  = div;
    bus_write(reg_cpol, to_word(reg_width'(model_cpol)), '1);
    bus_write(reg_cpha, to_word(reg_width'(model_cpha)), '1);
    bus_write(reg_chip_select, to_word(model_cs), '1);
    bus_write(reg_clock_div, to_word(model_div), '1);
    dev_cpol      = model_cpol;
    dev_cpha      = model_cpha;
    dev_resp      = resp;
    cs_expect     = ~(cs_line_count'(1) << sel);
    frames_before = dev_frames;
    bus_write(reg_tx_data, to_word(tx), '1);
    bus_read(reg_status, word);
    check_word("status after tx_data write", word, to_word(8'h01));
    // a second byte while busy must be dropped
    if (overwrite) begin
      bus_write(reg_tx_data, to_word(~tx), '1);
    end
    do begin
      bus_read(reg_status, word);
    end while (word[0] == 1'b1);
    check_word("status after transfer", word, '0);
    if (dev_frames != frames_before + 1) begin
      report_failure("the device did not see exactly one chip select frame");
    end
    check_byte("device received byte", dev_rx, tx);
    model_rx = resp;
    bus_read(reg_rx_data, word);
    check_word("rx_data", word, to_word(model_rx));
  endtask

  // the device model looks at the pins mid-cycle while they are stable
  always @(negedge clock) begin
    if (!reset) begin
      if (cs !== '1 && cs !== cs_expect) begin
        report_failure("a chip select line other than the addressed one went low");
      end
      selected = (cs_expect != '1) && (cs == cs_expect);
      if (selected && !selected_prev) begin
        dev_frames++;
        dev_shift = dev_resp;
        if (!dev_cpha) begin
          poci      = dev_shift[reg_width-1];
          dev_shift = {dev_shift[reg_width-2:0], 1'b0};
        end
      end
      if (selected && sclk != sclk_prev) begin
        // leading edge samples, trailing edge presents the next bit
        if ((sclk != dev_cpol) ^ dev_cpha) begin
          dev_rx = {dev_rx[reg_width-2:0], pico};
        end else begin
          poci      = dev_shift[reg_width-1];
          dev_shift = {dev_shift[reg_width-2:0], 1'b0};
        end
      end
      if (sclk != sclk_prev) begin
        sclk_edges++;
      end
      selected_prev = selected;
    end
    sclk_prev = sclk;
  end

  initial begin
    #(watchdog_cycles * clock_period);
    report_failure("the simulation timed out before all tests finished");
  end

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial begin
    logic [31:0]             pick;
    logic [31:0]             pick_tx;
    logic [31:0]             pick_resp;
    logic [1:0]              mode;
    logic [strobe_width-1:0] strobe;
    logic [data_width-1:0]   word;
    int                      edges_before;
    reset         = 1'b1;
    rw_address    = '0;
    write_data    = '0;
    write_strobe  = '0;
    read_request  = 1'b0;
    write_request = 1'b0;
    model_cpol    = 1'b0;
    model_cpha    = 1'b0;
    model_cs      = cs_none;
    model_div     = '0;
    model_rx      = '0;
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    check_registers();

    // random readback
    for (int round = 0; round < readback_rounds; round++) begin
      random_bits(18, pick);
      model_cpol = pick[17];
      model_cpha = pick[16];
      model_cs   = pick[15:8];
      model_div  = pick[7:0];
      pick_strobe(strobe);
      bus_write(reg_cpol, to_word(reg_width'(model_cpol)), strobe);
      pick_strobe(strobe);
      bus_write(reg_cpha, to_word(reg_width'(model_cpha)), strobe);
      pick_strobe(strobe);
      bus_write(reg_chip_select, to_word(model_cs), strobe);
      pick_strobe(strobe);
      bus_write(reg_clock_div, to_word(model_div), strobe);
      check_registers();
    end

    // illegal writes leave every register alone
    bus_write(reg_cpol, {31'h0000_0001, ~model_cpol}, '1);
    bus_write(reg_cpha, {31'h4000_0000, ~model_cpha}, '1);
    bus_write(reg_chip_select, {24'h00_0001, ~model_cs}, '1);
    bus_write(reg_clock_div, {24'h80_0000, ~model_div}, '1);
    bus_write(reg_cpol, to_word(reg_width'(~model_cpol)), '0);
    bus_write(reg_chip_select, to_word(~model_cs), '0);
    bus_write(reg_clock_div, to_word(~model_div), '0);
    check_registers();
    bus_read(5'h1c, word);
    check_word("unmapped 0x1c", word, read_idle_value);
    bus_read(5'h03, word);
    check_word("unmapped 0x03", word, read_idle_value);
    bus_read(reg_tx_data, word);
    check_word("tx_data readback", word, read_idle_value);

    // each mode once and then random modes
    for (int t = 0; t < transfer_count - 1; t++) begin
      random_bits(2, pick);
      mode = (t < 4) ? 2'(t) : pick[1:0];
      random_bits(8, pick);
      random_bits(8, pick_tx);
      random_bits(8, pick_resp);
      run_transfer(mode, 8'(pick % cs_line_count), {5'b0, pick[2:0]},
                   pick_tx[7:0], pick_resp[7:0], 1'b0);
    end

    random_bits(2, pick);
    random_bits(8, pick_tx);
    random_bits(8, pick_resp);
    run_transfer(pick[1:0], '0, 8'h03, pick_tx[7:0], pick_resp[7:0], 1'b1);

    // with no device selected nothing may start
    model_cs = cs_none;
    bus_write(reg_chip_select, to_word(cs_none), '1);
    cs_expect    = '1;
    edges_before = sclk_edges;
    random_bits(8, pick_tx);
    bus_write(reg_tx_data, to_word(pick_tx[7:0]), '1);
    bus_read(reg_status, word);
    check_word("status with no device selected", word, '0);
    check_registers();
    bus_read(reg_rx_data, word);
    check_word("rx_data with no device selected", word, to_word(model_rx));
    if (sclk_edges != edges_before) begin
      report_failure("sclk toggled although no device was selected");
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- verification/spi_controller_properties.sv
`timescale 1ns/1ps

module spi_controller_properties (
  input logic                                  clock,
  input logic                                  reset,
  input logic                                  read_request,
  input logic                                  read_response,
  input logic                                  write_request,
  input logic                                  write_response,
  input logic                                  busy,
  input logic                                  cpol,
  input logic                                  sclk,
  input logic [spi_map_pkg::cs_line_count-1:0] cs
);

  // ------------------------------------------------------------
  // bus handshake
  // ------------------------------------------------------------
  read_answered: assert property (@(posedge clock) disable iff (reset)
    read_request |=> read_response)
    else $error("read response missing one cycle after the request");

  read_requested: assert property (@(posedge clock) disable iff (reset)
    read_response |-> $past(read_request))
    else $error("read response without a request");

  write_answered: assert property (@(posedge clock) disable iff (reset)
    write_request |=> write_response)
    else $error("write response missing one cycle after the request");

  write_requested: assert property (@(posedge clock) disable iff (reset)
    write_response |-> $past(write_request))
    else $error("write response without a request");

  // ------------------------------------------------------------
  // spi pins
  // ------------------------------------------------------------
  // pad registers trail the sequencer by one clock
  cs_steady: assert property (@(posedge clock) disable iff (reset)
    $past(busy) && $past(busy, 2) |-> $stable(cs))
    else $error("chip select moved during a transfer");

  sclk_idle_level: assert property (@(posedge clock) disable iff (reset)
    !$past(busy) |-> (sclk == $past(cpol)))
    else $error("sclk away from its idle level outside a transfer");

endmodule

bind spi_controller spi_controller_properties i_properties (
  .clock          (clock),
  .reset          (reset),
  .read_request   (read_request),
  .read_response  (read_response),
  .write_request  (write_request),
  .write_response (write_response),
  .busy           (busy),
  .cpol           (cpol),
  .sclk           (sclk),
  .cs             (cs)
);

//--- src/spi_controller.sv
`timescale 1ns/1ps

module spi_controller (
  input  logic                                  clock,
  input  logic                                  reset,
  input  logic [spi_map_pkg::addr_width-1:0]    rw_address,
  output logic [spi_map_pkg::data_width-1:0]    read_data,
  input  logic                                  read_request,
  output logic                                  read_response,
  input  logic [spi_map_pkg::data_width-1:0]    write_data,
  input  logic [spi_map_pkg::strobe_width-1:0]  write_strobe,
  input  logic                                  write_request,
  output logic                                  write_response,
  output logic                                  sclk,
  output wire                                   pico,
  input  logic                                  poci,
  output logic [spi_map_pkg::cs_line_count-1:0] cs
);

  import spi_map_pkg::*;

  logic                     cpol;
  logic                     cpha;
  logic [reg_width-1:0]     chip_select;
  logic [reg_width-1:0]     clock_div;
  logic [reg_width-1:0]     tx_byte;
  logic [reg_width-1:0]     rx_byte;
  logic                     start;
  logic                     busy;
  logic                     active;
  logic                     sclk_next;
  logic                     shift_strobe;
  logic                     sample_strobe;
  logic [cs_line_count-1:0] cs_next;

  // ----------------------------------------------------------
  // register decode
  // ----------------------------------------------------------
  spi_regs i_regs (
    .clock          (clock),
    .reset          (reset),
    .rw_address     (rw_address),
    .read_request   (read_request),
    .write_request  (write_request),
    .write_data     (write_data),
    .write_strobe   (write_strobe),
    .read_data      (read_data),
    .read_response  (read_response),
    .write_response (write_response),
    .busy           (busy),
    .rx_byte        (rx_byte),
    .cpol           (cpol),
    .cpha           (cpha),
    .chip_select    (chip_select),
    .clock_div      (clock_div),
    .tx_byte        (tx_byte),
    .start          (start)
  );

  // ----------------------------------------------------------
  // sclk phases and strobes
  // ----------------------------------------------------------
  spi_sequencer i_sequencer (
    .clock         (clock),
    .reset         (reset),
    .cpol          (cpol),
    .cpha          (cpha),
    .clock_div     (clock_div),
    .chip_select   (chip_select),
    .start         (start),
    .busy          (busy),
    .active        (active),
    .sclk_next     (sclk_next),
    .shift_strobe  (shift_strobe),
    .sample_strobe (sample_strobe),
    .cs_next       (cs_next)
  );

  // load shares the start pulse
  spi_shifter i_shifter (
    .clock         (clock),
    .reset         (reset),
    .tx_byte       (tx_byte),
    .load          (start),
    .shift_strobe  (shift_strobe),
    .sample_strobe (sample_strobe),
    .active        (active),
    .sclk_next     (sclk_next),
    .cs_next       (cs_next),
    .poci          (poci),
    .rx_byte       (rx_byte),
    .sclk          (sclk),
    .pico          (pico),
    .cs            (cs)
  );

endmodule

//--- src/spi_shifter.sv
`timescale 1ns/1ps

module spi_shifter (
  input  logic                                   clock,
  input  logic                                   reset,
  input  logic [spi_engine_pkg::frame_width-1:0] tx_byte,
  input  logic                                   load,
  input  logic                                   shift_strobe,
  input  logic                                   sample_strobe,
  input  logic                                   active,
  input  logic                                   sclk_next,
  input  logic [spi_map_pkg::cs_line_count-1:0]  cs_next,
  input  logic                                   poci,
  output logic [spi_engine_pkg::frame_width-1:0] rx_byte,
  output logic                                   sclk,
  output wire                                    pico,
  output logic [spi_map_pkg::cs_line_count-1:0]  cs
);

  import spi_engine_pkg::*;

  logic [frame_width-1:0] tx_shift;
  logic                   pico_enable;

  // ----------------------------------------------------------
  // data shift registers
  // ----------------------------------------------------------
  // msb of tx_shift is the pico pin, so it moves on the same edge as sclk
  always_ff @(posedge clock) begin
    if (load) begin
      tx_shift <= tx_byte;
    end else if (shift_strobe) begin
      tx_shift <= {tx_shift[frame_width-2:0], 1'b0};
    end
  end

  always_ff @(posedge clock) begin
    if (sample_strobe) begin
      rx_byte <= {rx_byte[frame_width-2:0], poci};
    end
  end

  // ----------------------------------------------------------
  // pad registers
  // ----------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      sclk        <= 1'b0;
      cs          <= '1;
      pico_enable <= 1'b0;
    end else begin
      sclk        <= sclk_next;
      cs          <= cs_next;
      pico_enable <= active;
    end
  end

  // released while the sequencer sits in its ready state
  assign pico = pico_enable ? tx_shift[frame_width-1] : 1'bz;

endmodule

//--- src/spi_sequencer.sv
`timescale 1ns/1ps

module spi_sequencer (
  input  logic                                  clock,
  input  logic                                  reset,
  input  logic                                  cpol,
  input  logic                                  cpha,
  input  logic [spi_map_pkg::reg_width-1:0]     clock_div,
  input  logic [spi_map_pkg::reg_width-1:0]     chip_select,
  input  logic                                  start,
  output logic                                  busy,
  output logic                                  active,
  output logic                                  sclk_next,
  output logic                                  shift_strobe,
  output logic                                  sample_strobe,
  output logic [spi_map_pkg::cs_line_count-1:0] cs_next
);

  import spi_map_pkg::*;
  import spi_engine_pkg::*;

  spi_state_t                 state;
  spi_state_t                 state_next;
  spi_state_t                 first_phase;
  spi_state_t                 second_phase;
  logic                       deselect;
  logic                       half_done;
  logic                       leave_first;
  logic                       leave_second;
  logic                       last_bit;
  logic [reg_width-1:0]       half_count;
  logic [bit_index_width-1:0] bit_index;

  assign deselect = (chip_select == cs_none);

  // ----------------------------------------------------------
  // phase selection
  // ----------------------------------------------------------
  // each bit is a pair of half-periods. with cpha 0 the pair starts at the
  // idle level, with cpha 1 it starts with an sclk edge
  assign first_phase  = cpha ? spi_phase_b : spi_phase_a;
  assign second_phase = cpha ? spi_phase_a : spi_phase_b;

  assign half_done    = (half_count >= clock_div);
  assign last_bit     = (bit_index == '0);

  // leaving the first phase is the sample edge, leaving the second the shift edge
  assign leave_first  = (state == first_phase) && half_done;
  assign leave_second = (state == second_phase) && half_done;

  assign busy      = (state == spi_phase_a) || (state == spi_phase_b);
  assign active    = (state != spi_ready);
  assign sclk_next = (state == spi_phase_b) ? !cpol : cpol;

  // ----------------------------------------------------------
  // state machine
  // ----------------------------------------------------------
  always_comb begin
    state_next = state;
    case (state)
      spi_ready, spi_idle: begin
        if (start) begin
          state_next = first_phase;
        end
      end
      spi_phase_a, spi_phase_b: begin
        if (leave_first) begin
          state_next = second_phase;
        end else if (leave_second) begin
          state_next = last_bit ? spi_idle : first_phase;
        end
      end
      default: begin
        state_next = spi_ready;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset || deselect) begin
      state <= spi_ready;
    end else begin
      state <= state_next;
    end
  end

  // half-period counter, runs 0 to clock_div
  always_ff @(posedge clock) begin
    if (reset || !busy || half_done) begin
      half_count <= '0;
    end else begin
      half_count <= half_count + 1'b1;
    end
  end

  // bits left, counted down at the end of each pair
  always_ff @(posedge clock) begin
    if (reset || !busy) begin
      bit_index <= first_bit_index;
    end else if (leave_second && !last_bit) begin
      bit_index <= bit_index - 1'b1;
    end
  end

  // strobes land in the cycle the output register takes the new sclk level
  always_ff @(posedge clock) begin
    if (reset || deselect) begin
      sample_strobe <= 1'b0;
      shift_strobe  <= 1'b0;
    end else begin
      sample_strobe <= leave_first;
      shift_strobe  <= leave_second && !last_bit;
    end
  end

  // active-low select, only the addressed line and only during a transfer
  always_comb begin
    for (int i = 0; i < cs_line_count; i++) begin
      cs_next[i] = !(busy && (chip_select == reg_width'(i)));
    end
  end

endmodule

//--- src/spi_regs.sv
`timescale 1ns/1ps

module spi_regs (
  input  logic                                 clock,
  input  logic                                 reset,
  input  logic [spi_map_pkg::addr_width-1:0]   rw_address,
  input  logic                                 read_request,
  input  logic                                 write_request,
  input  logic [spi_map_pkg::data_width-1:0]   write_data,
  input  logic [spi_map_pkg::strobe_width-1:0] write_strobe,
  output logic [spi_map_pkg::data_width-1:0]   read_data,
  output logic                                 read_response,
  output logic                                 write_response,
  input  logic                                 busy,
  input  logic [spi_map_pkg::reg_width-1:0]    rx_byte,
  output logic                                 cpol,
  output logic                                 cpha,
  output logic [spi_map_pkg::reg_width-1:0]    chip_select,
  output logic [spi_map_pkg::reg_width-1:0]    clock_div,
  output logic [spi_map_pkg::reg_width-1:0]    tx_byte,
  output logic                                 start
);

  import spi_map_pkg::*;

  logic                  write_valid;
  logic                  bit_write_ok;
  logic                  byte_write_ok;
  logic                  cpol_write;
  logic                  cpha_write;
  logic                  cs_write;
  logic                  div_write;
  logic                  tx_write;
  logic                  tx_accept;
  logic                  engine_busy;
  logic [data_width-1:0] read_word;

  // ----------------------------------------------------------
  // write decode
  // ----------------------------------------------------------
  // a write needs at least one strobe and clear bits above the register
  assign write_valid   = write_request && (|write_strobe);
  assign bit_write_ok  = write_valid && (write_data[data_width-1:1] == '0);
  assign byte_write_ok = write_valid && (write_data[data_width-1:reg_width] == '0);

  assign cpol_write = bit_write_ok && (rw_address == reg_cpol);
  assign cpha_write = bit_write_ok && (rw_address == reg_cpha);
  assign cs_write   = byte_write_ok && (rw_address == reg_chip_select);
  assign div_write  = byte_write_ok && (rw_address == reg_clock_div);
  assign tx_write   = byte_write_ok && (rw_address == reg_tx_data);

  // a pending start counts as busy, so a back-to-back write cannot reload the shifter
  assign engine_busy = busy || start;

  // no selected device means no transfer
  assign tx_accept = tx_write && !engine_busy && (chip_select != cs_none);

  // every request gets its response on the next cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      read_response  <= 1'b0;
      write_response <= 1'b0;
    end else begin
      read_response  <= read_request;
      write_response <= write_request;
    end
  end

  // ----------------------------------------------------------
  // configuration registers
  // ----------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      cpol        <= 1'b0;
      cpha        <= 1'b0;
      chip_select <= cs_none;
      clock_div   <= '0;
      start       <= 1'b0;
    end else begin
      if (cpol_write) begin
        cpol <= write_data[0];
      end
      if (cpha_write) begin
        cpha <= write_data[0];
      end
      if (cs_write) begin
        chip_select <= write_data[reg_width-1:0];
      end
      if (div_write) begin
        clock_div <= write_data[reg_width-1:0];
      end
      start <= tx_accept;
    end
  end

  always_ff @(posedge clock) begin
    if (tx_accept) begin
      tx_byte <= write_data[reg_width-1:0];
    end
  end

  // ----------------------------------------------------------
  // read mux
  // ----------------------------------------------------------
  // tx_data is write only and reads like an unmapped address
  always_comb begin
    read_word = read_idle_value;
    if (read_request) begin
      case (rw_address)
        reg_cpol:        read_word = {{(data_width - 1){1'b0}}, cpol};
        reg_cpha:        read_word = {{(data_width - 1){1'b0}}, cpha};
        reg_chip_select: read_word = {{(data_width - reg_width){1'b0}}, chip_select};
        reg_clock_div:   read_word = {{(data_width - reg_width){1'b0}}, clock_div};
        reg_rx_data:     read_word = {{(data_width - reg_width){1'b0}}, rx_byte};
        reg_status:      read_word = {{(data_width - 1){1'b0}}, engine_busy};
        default:         read_word = read_idle_value;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      read_data <= read_idle_value;
    end else begin
      read_data <= read_word;
    end
  end

endmodule

//--- src/spi_engine_pkg.sv
package spi_engine_pkg;

  // ----------------------------------------------------------
  // sequencer states, one-hot
  // ----------------------------------------------------------
  // phase_a keeps sclk at the cpol level, phase_b drives it inverted
  typedef enum logic [3:0] {
    spi_ready   = 4'b0001,
    spi_idle    = 4'b0010,
    spi_phase_a = 4'b0100,
    spi_phase_b = 4'b1000
  } spi_state_t;

  // ----------------------------------------------------------
  // transfer framing
  // ----------------------------------------------------------
  localparam int unsigned bit_index_width = 3;

  // bits moved per transfer
  localparam int unsigned frame_width = 1 << bit_index_width;

  // bit counter start value, msb goes out first
  localparam logic [bit_index_width-1:0] first_bit_index =
    bit_index_width'(frame_width - 1);

endpackage

//--- src/spi_map_pkg.sv
package spi_map_pkg;

  // ----------------------------------------------------------
  // bus geometry
  // ----------------------------------------------------------
  localparam int unsigned addr_width   = 5;
  localparam int unsigned data_width   = 32;
  localparam int unsigned strobe_width = 4;

  // chip select index, clock divider, tx and rx data are byte wide
  localparam int unsigned reg_width = 8;

  // number of chip-select pins, the design handles up to 8
  localparam int unsigned cs_line_count = 1;

  // ----------------------------------------------------------
  // register map
  // ----------------------------------------------------------
  localparam logic [addr_width-1:0] reg_cpol        = 5'h00;
  localparam logic [addr_width-1:0] reg_cpha        = 5'h04;
  localparam logic [addr_width-1:0] reg_chip_select = 5'h08;
  localparam logic [addr_width-1:0] reg_clock_div   = 5'h0c;
  localparam logic [addr_width-1:0] reg_tx_data     = 5'h10;
  localparam logic [addr_width-1:0] reg_rx_data     = 5'h14;
  localparam logic [addr_width-1:0] reg_status      = 5'h18;

  // returned on reset, between reads and for unmapped addresses
  localparam logic [data_width-1:0] read_idle_value = 32'hdeadbeef;

  // chip select index that deselects every line
  localparam logic [reg_width-1:0] cs_none = 8'hff;

endpackage
